//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module llki_pp_tb -f sim.f -o llki_pp_sim

run: build
	./obj_dir/llki_pp_sim +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -Wall --top-module llki_pp_tb -f sim.f

clean:
	rm -rf obj_dir $(LOG)

//--- sim.f
source/llki_pkg.sv
source/llki_reg_port.sv
source/llki_reg_decode.sv
source/llki_msg_fsm.sv
source/llki_pp.sv
tb/llki_pp_chk.sv
tb/llki_pp_tb.sv

//--- source/llki_msg_fsm.sv
/*
  Key loading protocol FSM, one request at a time, no message buffering.
  Host must poll ready-for-key before each key word, a word sent while the core
  is not ready ends the load with a loss-of-sync error.
  Writes to send/receive outside IDLE and LOAD_KEY are ignored.
*/
`default_nettype none

module llki_msg_fsm (
  input  logic                          clk,
  input  logic                          rst,
  // From the register decoder
  input  logic                          send_wr_i,
  input  logic                          send_rd_i,
  input  logic [llki_pkg::DATA_W-1:0]   wdata_i,
  output logic [llki_pkg::DATA_W-1:0]   resp_word_o,
  output logic                          resp_waiting_o,
  // Core discrete key port
  output logic [llki_pkg::KEY_W-1:0]    key_data_o,
  output logic                          key_valid_o,
  input  logic                          key_ready_i,
  input  logic                          key_complete_i,
  output logic                          clear_key_o,
  input  logic                          clear_ack_i
);

  llki_pkg::pp_state_t  state_q;
  llki_pkg::msg_word_t  wr_word;
  llki_pkg::msg_word_t  resp_word;
  logic [7:0]           msg_id_q;
  logic [7:0]           status_q;
  logic [7:0]           msg_len_q;
  logic                 key_accept;

  assign wr_word.raw = wdata_i;

  // Key word goes out only when the core can take it
  assign key_accept = (state_q == llki_pkg::LOAD_KEY) & send_wr_i
                    & key_ready_i & ~key_complete_i;

  // ----------------------------------------------------------------------
  // Protocol FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= llki_pkg::IDLE;
      msg_id_q    <= '0;
      status_q    <= '0;
      msg_len_q   <= '0;
      key_valid_o <= 1'b0;
      clear_key_o <= 1'b0;
    end else begin
      key_valid_o <= 1'b0;
      case (state_q)
        llki_pkg::IDLE: begin
          // Header view of the request word
          if (send_wr_i) begin
            msg_id_q  <= wr_word.hdr.msg_id;
            status_q  <= wr_word.hdr.status;
            msg_len_q <= wr_word.hdr.msg_len;
            state_q   <= llki_pkg::MSG_CHECK;
          end
        end
        llki_pkg::MSG_CHECK: begin
          state_q <= llki_pkg::RESPONSE;
          case (msg_id_q)
            llki_pkg::MID_LOAD_KEY_REQ: begin
              // Header plus at least one key word
              if (msg_len_q <= 8'd1) begin
                msg_id_q <= llki_pkg::MID_ERROR_RESP;
                status_q <= llki_pkg::ST_BAD_MSG_LEN;
              end else begin
                state_q  <= llki_pkg::LOAD_KEY;
              end
            end
            llki_pkg::MID_CLEAR_KEY_REQ: begin
              if (msg_len_q != 8'd1) begin
                msg_id_q <= llki_pkg::MID_ERROR_RESP;
                status_q <= llki_pkg::ST_BAD_MSG_LEN;
              end else begin
                clear_key_o <= 1'b1;
                state_q     <= llki_pkg::CLEAR_KEY;
              end
            end
            llki_pkg::MID_KEY_STATUS_REQ: begin
              if (msg_len_q != 8'd1) begin
                msg_id_q <= llki_pkg::MID_ERROR_RESP;
                status_q <= llki_pkg::ST_BAD_MSG_LEN;
              end else begin
                msg_id_q <= llki_pkg::MID_KEY_STATUS_RESP;
                status_q <= key_complete_i ? llki_pkg::ST_KEY_PRESENT
                                           : llki_pkg::ST_KEY_NOT_PRESENT;
              end
            end
            default: begin
              msg_id_q <= llki_pkg::MID_ERROR_RESP;
              status_q <= llki_pkg::ST_BAD_MSG_ID;
            end
          endcase
        end
        llki_pkg::LOAD_KEY: begin
          if (send_wr_i) begin
            if (!key_ready_i) begin
              // Word dropped, host lost track of the core
              msg_id_q <= llki_pkg::MID_ERROR_RESP;
              status_q <= llki_pkg::ST_LOSS_OF_SYNC;
              state_q  <= llki_pkg::RESPONSE;
            end else if (key_complete_i) begin
              // Too many words for this core, wipe the partial key
              msg_id_q    <= llki_pkg::MID_ERROR_RESP;
              status_q    <= llki_pkg::ST_BAD_KEY_LEN;
              clear_key_o <= 1'b1;
              state_q     <= llki_pkg::CLEAR_KEY;
            end else begin
              key_valid_o <= 1'b1;
              // msg_len counts the header too, so 2 means last word
              if (msg_len_q == 8'd2) begin
                msg_id_q <= llki_pkg::MID_LOAD_KEY_ACK;
                status_q <= llki_pkg::ST_GOOD;
                state_q  <= llki_pkg::RESPONSE;
              end else begin
                msg_len_q <= msg_len_q - 8'd1;
              end
            end
          end
        end
        llki_pkg::CLEAR_KEY: begin
          if (clear_ack_i) begin
            clear_key_o <= 1'b0;
            // Keep a pending bad key length error
            if (msg_id_q != llki_pkg::MID_ERROR_RESP) begin
              msg_id_q <= llki_pkg::MID_CLEAR_KEY_ACK;
              status_q <= llki_pkg::ST_GOOD;
            end
            state_q <= llki_pkg::RESPONSE;
          end
        end
        llki_pkg::RESPONSE: begin
          // Host read of send/receive consumes the response
          if (send_rd_i) begin
            state_q <= llki_pkg::IDLE;
          end
        end
        default: begin
          clear_key_o <= 1'b0;
          state_q     <= llki_pkg::IDLE;
        end
      endcase
    end
  end

  // Key word register, raw view zero extended
  always_ff @(posedge clk) begin
    if (key_accept) begin
      key_data_o <= {{(llki_pkg::KEY_W - llki_pkg::DATA_W){1'b0}}, wr_word.raw};
    end
  end

  // ----------------------------------------------------------------------
  // Response word
  // ----------------------------------------------------------------------
  assign resp_waiting_o = (state_q == llki_pkg::RESPONSE);

  always_comb begin
    resp_word.hdr.reserved = '0;
    resp_word.hdr.msg_len  = 8'd1;
    resp_word.hdr.status   = status_q;
    resp_word.hdr.msg_id   = msg_id_q;
  end

  // Reads as zero when no response is pending
  assign resp_word_o = resp_waiting_o ? resp_word.raw : '0;

endmodule

`default_nettype wire

//--- source/llki_pkg.sv
/*
  Shared widths, message ids, status codes and state type of the key loader.
  Message words are DATA_W wide, and key words are the written word zero extended to KEY_W.
  Encodings must match the host software that builds the request words.
*/
`default_nettype none

package llki_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int KEY_W  = 64;

  // Bit positions in the control/status word
  localparam int CTRLSTS_RESP_WAITING  = 0;
  localparam int CTRLSTS_READY_FOR_KEY = 1;

  // ----------------------------------------------------------------------
  // Message ids
  // ----------------------------------------------------------------------
  // Requests from the host
  localparam logic [7:0] MID_LOAD_KEY_REQ    = 8'h00;
  localparam logic [7:0] MID_CLEAR_KEY_REQ   = 8'h01;
  localparam logic [7:0] MID_KEY_STATUS_REQ  = 8'h02;
  // Responses to the host
  localparam logic [7:0] MID_LOAD_KEY_ACK    = 8'h03;
  localparam logic [7:0] MID_CLEAR_KEY_ACK   = 8'h04;
  localparam logic [7:0] MID_KEY_STATUS_RESP = 8'h05;
  localparam logic [7:0] MID_ERROR_RESP      = 8'h06;

  // ----------------------------------------------------------------------
  // Status codes
  // ----------------------------------------------------------------------
  localparam logic [7:0] ST_GOOD            = 8'h00;
  localparam logic [7:0] ST_KEY_PRESENT     = 8'h01;
  localparam logic [7:0] ST_KEY_NOT_PRESENT = 8'h02;
  localparam logic [7:0] ST_BAD_MSG_ID      = 8'h20;
  localparam logic [7:0] ST_BAD_MSG_LEN     = 8'h21;
  localparam logic [7:0] ST_BAD_KEY_LEN     = 8'h22;
  localparam logic [7:0] ST_LOSS_OF_SYNC    = 8'h23;

  // Protocol FSM states
  typedef enum logic [2:0] {
    IDLE,
    MSG_CHECK,
    LOAD_KEY,
    CLEAR_KEY,
    RESPONSE
  } pp_state_t;

  // Header layout, msg_id in the low byte
  typedef struct packed {
    logic [7:0] reserved;
    logic [7:0] msg_len;
    logic [7:0] status;
    logic [7:0] msg_id;
  } msg_hdr_t;

  // Send/receive word, a header or a raw key word depending on FSM state
  typedef union packed {
    msg_hdr_t            hdr;
    logic [DATA_W-1:0]   raw;
  } msg_word_t;

endpackage

`default_nettype wire

//--- source/llki_pp.sv
/*
  Key loading protocol processor top level.
  Register addresses are set here and must be distinct.
*/
`default_nettype none

module llki_pp #(
  parameter logic [llki_pkg::ADDR_W-1:0] CTRLSTS_ADDR  = 32'h0000_0000,
  parameter logic [llki_pkg::ADDR_W-1:0] SENDRECV_ADDR = 32'h0000_0008
) (
  input  logic                          clk,
  input  logic                          rst,
  // Host register port
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [llki_pkg::ADDR_W-1:0]   addr_i,
  input  logic [llki_pkg::DATA_W-1:0]   wdata_i,
  output logic                          ack_o,
  output logic [llki_pkg::DATA_W-1:0]   rdata_o,
  output logic                          err_o,
  // Core discrete key port
  output logic [llki_pkg::KEY_W-1:0]    key_data_o,
  output logic                          key_valid_o,
  input  logic                          key_ready_i,
  input  logic                          key_complete_i,
  output logic                          clear_key_o,
  input  logic                          clear_ack_i
);

  // Port to decode
  logic                          wr_stb;
  logic                          rd_stb;
  logic [llki_pkg::ADDR_W-1:0]   reg_addr;
  logic [llki_pkg::DATA_W-1:0]   reg_wdata;
  logic [llki_pkg::DATA_W-1:0]   reg_rdata;
  logic                          reg_err;
  // Decode to FSM
  logic                          send_wr;
  logic                          send_rd;
  logic [llki_pkg::DATA_W-1:0]   resp_word;
  logic                          resp_waiting;

  // ----------------------------------------------------------------------
  // Bus port, decode, protocol FSM
  // ----------------------------------------------------------------------
  llki_reg_port reg_port_inst (
    .clk      (clk),
    .rst      (rst),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .ack_o    (ack_o),
    .rdata_o  (rdata_o),
    .err_o    (err_o),
    .rdata_i  (reg_rdata),
    .err_i    (reg_err),
    .wr_stb_o (wr_stb),
    .rd_stb_o (rd_stb),
    .addr_o   (reg_addr),
    .wdata_o  (reg_wdata)
  );

  llki_reg_decode #(
    .CTRLSTS_ADDR  (CTRLSTS_ADDR),
    .SENDRECV_ADDR (SENDRECV_ADDR)
  ) reg_decode_inst (
    .clk            (clk),
    .rst            (rst),
    .wr_stb_i       (wr_stb),
    .rd_stb_i       (rd_stb),
    .addr_i         (reg_addr),
    .rdata_o        (reg_rdata),
    .err_o          (reg_err),
    .resp_word_i    (resp_word),
    .resp_waiting_i (resp_waiting),
    .key_ready_i    (key_ready_i),
    .send_wr_o      (send_wr),
    .send_rd_o      (send_rd)
  );

  // Write data bypasses the decoder, only the strobe is qualified there
  llki_msg_fsm msg_fsm_inst (
    .clk            (clk),
    .rst            (rst),
    .send_wr_i      (send_wr),
    .send_rd_i      (send_rd),
    .wdata_i        (reg_wdata),
    .resp_word_o    (resp_word),
    .resp_waiting_o (resp_waiting),
    .key_data_o     (key_data_o),
    .key_valid_o    (key_valid_o),
    .key_ready_i    (key_ready_i),
    .key_complete_i (key_complete_i),
    .clear_key_o    (clear_key_o),
    .clear_ack_i    (clear_ack_i)
  );

endmodule

`default_nettype wire

//--- source/llki_reg_decode.sv
/*
  Register decode for the control/status and send/receive words.
  Status bits lag resp_waiting and key_ready by one cycle.
  Control/status has no writable bits, a write there is accepted and dropped.
  CTRLSTS_ADDR and SENDRECV_ADDR must differ.
*/
`default_nettype none

module llki_reg_decode #(
  parameter logic [llki_pkg::ADDR_W-1:0] CTRLSTS_ADDR  = 32'h0000_0000,
  parameter logic [llki_pkg::ADDR_W-1:0] SENDRECV_ADDR = 32'h0000_0008
) (
  input  logic                          clk,
  input  logic                          rst,
  // Access strobes from the register port
  input  logic                          wr_stb_i,
  input  logic                          rd_stb_i,
  input  logic [llki_pkg::ADDR_W-1:0]   addr_i,
  output logic [llki_pkg::DATA_W-1:0]   rdata_o,
  output logic                          err_o,
  // Protocol FSM side
  input  logic [llki_pkg::DATA_W-1:0]   resp_word_i,
  input  logic                          resp_waiting_i,
  input  logic                          key_ready_i,
  output logic                          send_wr_o,
  output logic                          send_rd_o
);

  logic                          resp_waiting_q;
  logic                          ready_for_key_q;
  logic [llki_pkg::DATA_W-1:0]   ctrlsts_word;
  logic                          hit_ctrlsts;
  logic                          hit_sendrecv;

  // ----------------------------------------------------------------------
  // Control/status register
  // ----------------------------------------------------------------------
  // Sampled every cycle, host polls these bits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      resp_waiting_q  <= 1'b0;
      ready_for_key_q <= 1'b0;
    end else begin
      resp_waiting_q  <= resp_waiting_i;
      ready_for_key_q <= key_ready_i;
    end
  end

  // Remaining bits read as zero
  always_comb begin
    ctrlsts_word = '0;
    ctrlsts_word[llki_pkg::CTRLSTS_RESP_WAITING]  = resp_waiting_q;
    ctrlsts_word[llki_pkg::CTRLSTS_READY_FOR_KEY] = ready_for_key_q;
  end

  // ----------------------------------------------------------------------
  // Address decode and read mux
  // ----------------------------------------------------------------------
  assign hit_ctrlsts  = (addr_i == CTRLSTS_ADDR);
  assign hit_sendrecv = (addr_i == SENDRECV_ADDR);

  always_comb begin
    rdata_o = '0;
    if (rd_stb_i) begin
      if (hit_ctrlsts) begin
        rdata_o = ctrlsts_word;
      end else if (hit_sendrecv) begin
        rdata_o = resp_word_i;
      end
    end
  end

  // Any access outside the two registers is flagged
  assign err_o = (wr_stb_i | rd_stb_i) & ~hit_ctrlsts & ~hit_sendrecv;

  // Send/receive accesses go on to the FSM
  assign send_wr_o = wr_stb_i & hit_sendrecv;
  assign send_rd_o = rd_stb_i & hit_sendrecv;

endmodule

`default_nettype wire

//--- source/llki_reg_port.sv
/*
  Four-phase req/ack register port, one access in flight at a time.
  Host keeps we_i, addr_i and wdata_i stable while req_i is high.
  A held req_i holds ack_o, rdata_o and err_o and blocks new accesses.
*/
`default_nettype none

module llki_reg_port (
  input  logic                          clk,
  input  logic                          rst,
  // Host side
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [llki_pkg::ADDR_W-1:0]   addr_i,
  input  logic [llki_pkg::DATA_W-1:0]   wdata_i,
  output logic                          ack_o,
  output logic [llki_pkg::DATA_W-1:0]   rdata_o,
  output logic                          err_o,
  // Decoder side
  input  logic [llki_pkg::DATA_W-1:0]   rdata_i,
  input  logic                          err_i,
  output logic                          wr_stb_o,
  output logic                          rd_stb_o,
  output logic [llki_pkg::ADDR_W-1:0]   addr_o,
  output logic [llki_pkg::DATA_W-1:0]   wdata_o
);

  // Handshake states
  localparam logic [1:0] HS_IDLE   = 2'd0;
  localparam logic [1:0] HS_ACCESS = 2'd1;
  localparam logic [1:0] HS_ACK    = 2'd2;

  logic [1:0] hs_state_q;

  // ----------------------------------------------------------------------
  // Handshake FSM and strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hs_state_q <= HS_IDLE;
      wr_stb_o   <= 1'b0;
      rd_stb_o   <= 1'b0;
      ack_o      <= 1'b0;
    end else begin
      // Strobes last a single cycle
      wr_stb_o <= 1'b0;
      rd_stb_o <= 1'b0;
      case (hs_state_q)
        HS_IDLE: begin
          // ack_o is low here, so a high req_i is a new access
          if (req_i) begin
            wr_stb_o   <= we_i;
            rd_stb_o   <= ~we_i;
            hs_state_q <= HS_ACCESS;
          end
        end
        HS_ACCESS: begin
          // Decoder answers during the strobe cycle
          ack_o      <= 1'b1;
          hs_state_q <= HS_ACK;
        end
        HS_ACK: begin
          if (!req_i) begin
            ack_o      <= 1'b0;
            hs_state_q <= HS_IDLE;
          end
        end
        default: begin
          ack_o      <= 1'b0;
          hs_state_q <= HS_IDLE;
        end
      endcase
    end
  end

  // Request capture and response hold registers
  always_ff @(posedge clk) begin
    if (hs_state_q == HS_IDLE && req_i) begin
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
    end
    // Latched once, stays put through the whole acknowledge phase
    if (hs_state_q == HS_ACCESS) begin
      rdata_o <= rdata_i;
      err_o   <= err_i;
    end
  end

endmodule

`default_nettype wire

//--- tb/llki_pp_chk.sv
/*
  Concurrent checks on the register handshake and the core key port.
  Bound into llki_pp. fail_count counts the failed assertions.
*/
`default_nettype none

module llki_pp_chk (
  input  logic clk,
  input  logic rst,
  input  logic req_i,
  input  logic ack_o,
  input  logic key_valid_o,
  input  logic clear_key_o,
  input  logic clear_ack_i
);

  int fail_count = 0;

  // ----------------------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------------------
  // Ack only answers a live request
  // Req is taken one cycle back since the host may drop it once ack is seen
  ack_in_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack_o) |-> $past(req_i))
    else begin
      $error("ack_o rose although req_i was low in the cycle before");
      fail_count++;
    end

  // Ack starts low when reset is released
  ack_reset: assert property (@(posedge clk) $fell(rst) |-> !ack_o)
    else begin
      $error("ack_o is high right after reset");
      fail_count++;
    end

  // ----------------------------------------------------------------------
  // Core key port rules
  // ----------------------------------------------------------------------
  key_pulse: assert property (@(posedge clk) disable iff (rst)
    key_valid_o |=> !key_valid_o)
    else begin
      $error("key_valid_o stayed high for two cycles");
      fail_count++;
    end

  // Clear request holds until the core acknowledges
  clear_hold: assert property (@(posedge clk) disable iff (rst)
    (clear_key_o && !clear_ack_i) |=> clear_key_o)
    else begin
      $error("clear_key_o dropped before clear_ack_i");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tb/llki_pp_tb.sv
/*
  Testbench for the key loading protocol processor.
  Core model holds key_ready high and reports a complete key after KEY_LEN words.
  Inputs change on the falling edge and outputs are sampled there as well.
*/
`default_nettype none

module llki_pp_tb;

  localparam logic [31:0] CTRLSTS_ADDR  = 32'h0000_0000;
  localparam logic [31:0] SENDRECV_ADDR = 32'h0000_0008;
  localparam int          KEY_LEN       = 4;
  localparam int          ACK_LIMIT     = 100;
  localparam int          POLL_LIMIT    = 50;

  logic                          clk = 1'b0;
  logic                          rst = 1'b1;
  logic                          req;
  logic                          we;
  logic [llki_pkg::ADDR_W-1:0]   addr;
  logic [llki_pkg::DATA_W-1:0]   wdata;
  logic                          ack;
  logic [llki_pkg::DATA_W-1:0]   rdata;
  logic                          err;
  logic [llki_pkg::KEY_W-1:0]    key_data;
  logic                          key_valid;
  logic                          key_ready = 1'b1;
  logic                          key_complete;
  logic                          clear_key;
  logic                          clear_ack = 1'b0;

  // Core model state
  int                            key_count   = 0;
  int                            clear_wait  = 0;
  int                            clear_count = 0;
  logic                          clear_busy  = 1'b0;
  integer                        seed        = 32'hdcf7;
  logic [63:0]                   key_seen[$];
  logic [63:0]                   exp_keys[$];
  int                            checks = 0;
  int                            errors = 0;

  always #4 clk = ~clk;

  llki_pp #(
    .CTRLSTS_ADDR  (CTRLSTS_ADDR),
    .SENDRECV_ADDR (SENDRECV_ADDR)
  ) llki_pp_inst (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req),
    .we_i           (we),
    .addr_i         (addr),
    .wdata_i        (wdata),
    .ack_o          (ack),
    .rdata_o        (rdata),
    .err_o          (err),
    .key_data_o     (key_data),
    .key_valid_o    (key_valid),
    .key_ready_i    (key_ready),
    .key_complete_i (key_complete),
    .clear_key_o    (clear_key),
    .clear_ack_i    (clear_ack)
  );

  bind llki_pp llki_pp_chk chk_inst (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .key_valid_o (key_valid_o),
    .clear_key_o (clear_key_o),
    .clear_ack_i (clear_ack_i)
  );

  // ----------------------------------------------------------------------
  // Core model
  // ----------------------------------------------------------------------
  assign key_complete = (key_count >= KEY_LEN);

  always @(negedge clk) begin
    if (!rst) begin
      if (key_valid) begin
        key_count <= key_count + 1;
        key_seen.push_back(key_data);
      end
      // Clear ack is a one-cycle pulse after a random delay
      if (clear_ack) begin
        clear_ack  <= 1'b0;
        clear_busy <= 1'b0;
        key_count  <= 0;
      end else if (clear_busy) begin
        if (clear_wait == 0) begin
          clear_ack <= 1'b1;
        end else begin
          clear_wait <= clear_wait - 1;
        end
      end else if (clear_key) begin
        clear_busy  <= 1'b1;
        clear_wait  <= $random(seed) & 32'h7;
        clear_count <= clear_count + 1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------------------
  task automatic finish_run();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, llki_pp_inst.chk_inst.fail_count);
    if (errors == 0 && llki_pp_inst.chk_inst.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("timeout at %0t: gave up waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Host access, entered and left on a falling edge
  // ----------------------------------------------------------------------
  task automatic bus_handshake(input logic write, input logic [31:0] a,
                               input logic [31:0] d, output logic [31:0] rd,
                               output logic e);
    int cycles;
    cycles = 0;
    we     = write;
    addr   = a;
    wdata  = d;
    req    = 1'b1;
    while (ack !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_LIMIT) timeout_fail("ack_o to rise");
    end
    rd     = rdata;
    e      = err;
    req    = 1'b0;
    cycles = 0;
    while (ack !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_LIMIT) timeout_fail("ack_o to fall");
    end
  endtask

  task automatic host_write(input logic [31:0] a, input logic [31:0] d, output logic e);
    logic [31:0] ignored;
    bus_handshake(1'b1, a, d, ignored, e);
  endtask

  task automatic host_read(input logic [31:0] a, output logic [31:0] rd, output logic e);
    bus_handshake(1'b0, a, 32'd0, rd, e);
  endtask

  // Poll control/status until the given bit is set
  task automatic wait_status(input int bit_pos, input string what);
    logic [31:0] sts;
    logic        e;
    int          polls;
    polls = 0;
    host_read(CTRLSTS_ADDR, sts, e);
    while (sts[bit_pos] !== 1'b1) begin
      polls++;
      if (polls > POLL_LIMIT) timeout_fail(what);
      host_read(CTRLSTS_ADDR, sts, e);
    end
  endtask

  // ----------------------------------------------------------------------
  // Protocol helpers
  // ----------------------------------------------------------------------
  task automatic send_header(input logic [7:0] id, input logic [7:0] len);
    llki_pkg::msg_word_t w;
    logic                e;
    w.raw         = '0;
    w.hdr.msg_id  = id;
    w.hdr.msg_len = len;
    host_write(SENDRECV_ADDR, w.raw, e);
    check_value({63'd0, e}, 64'd0, "err_o on header write");
  endtask

  // Response is one word, length 1, reserved byte zero
  task automatic expect_response(input logic [7:0] id, input logic [7:0] st,
                                 input string what);
    llki_pkg::msg_word_t exp_w;
    logic [31:0]         got;
    logic                e;
    exp_w.raw         = '0;
    exp_w.hdr.msg_id  = id;
    exp_w.hdr.status  = st;
    exp_w.hdr.msg_len = 8'd1;
    wait_status(llki_pkg::CTRLSTS_RESP_WAITING, "response waiting bit");
    host_read(SENDRECV_ADDR, got, e);
    check_value({63'd0, e}, 64'd0, {what, " err_o"});
    check_value({32'd0, got}, {32'd0, exp_w.raw}, what);
  endtask

  task automatic check_key_status(input logic present);
    send_header(llki_pkg::MID_KEY_STATUS_REQ, 8'd1);
    expect_response(llki_pkg::MID_KEY_STATUS_RESP,
                    present ? llki_pkg::ST_KEY_PRESENT : llki_pkg::ST_KEY_NOT_PRESENT,
                    "key status");
  endtask

  // Each word waits for ready-for-key, expected pulse is the word zero extended
  task automatic load_key_words(input int n, input logic [31:0] base);
    logic [31:0] word;
    logic        e;
    for (int i = 0; i < n; i++) begin
      word = base ^ (32'h0101_0101 * i);
      wait_status(llki_pkg::CTRLSTS_READY_FOR_KEY, "ready for key bit");
      host_write(SENDRECV_ADDR, word, e);
      exp_keys.push_back({32'd0, word});
    end
  endtask

  task automatic compare_keys();
    check_value(64'(key_seen.size()), 64'(exp_keys.size()), "key_valid pulse count");
    for (int i = 0; i < exp_keys.size() && i < key_seen.size(); i++) begin
      check_value(key_seen[i], exp_keys[i], "key_data_o");
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic        e;
    int          clears_before;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    check_key_status(1'b0);

    // Full key load
    send_header(llki_pkg::MID_LOAD_KEY_REQ, 8'(KEY_LEN + 1));
    load_key_words(KEY_LEN, 32'hc0de_0000);
    expect_response(llki_pkg::MID_LOAD_KEY_ACK, llki_pkg::ST_GOOD, "load key ack");
    compare_keys();
    check_key_status(1'b1);

    // Malformed requests
    send_header(8'h7f, 8'd1);
    expect_response(llki_pkg::MID_ERROR_RESP, llki_pkg::ST_BAD_MSG_ID, "unknown id");
    send_header(llki_pkg::MID_CLEAR_KEY_REQ, 8'd2);
    expect_response(llki_pkg::MID_ERROR_RESP, llki_pkg::ST_BAD_MSG_LEN, "clear of length 2");
    send_header(llki_pkg::MID_LOAD_KEY_REQ, 8'd1);
    expect_response(llki_pkg::MID_ERROR_RESP, llki_pkg::ST_BAD_MSG_LEN, "load of length 1");
    check_key_status(1'b1);

    // Clear
    clears_before = clear_count;
    send_header(llki_pkg::MID_CLEAR_KEY_REQ, 8'd1);
    expect_response(llki_pkg::MID_CLEAR_KEY_ACK, llki_pkg::ST_GOOD, "clear key ack");
    check_value(64'(clear_count - clears_before), 64'd1, "clear_key_o requests");
    check_key_status(1'b0);

    // One word more than the core takes
    clears_before = clear_count;
    send_header(llki_pkg::MID_LOAD_KEY_REQ, 8'(KEY_LEN + 2));
    load_key_words(KEY_LEN, 32'h5a5a_0000);
    wait_status(llki_pkg::CTRLSTS_READY_FOR_KEY, "ready for key bit");
    host_write(SENDRECV_ADDR, 32'hdead_beef, e);
    expect_response(llki_pkg::MID_ERROR_RESP, llki_pkg::ST_BAD_KEY_LEN, "bad key length");
    check_value(64'(clear_count - clears_before), 64'd1, "clear after bad key length");
    compare_keys();
    check_key_status(1'b0);

    // Unmapped addresses flag an error, control/status write is ignored
    host_read(32'h0000_0010, rd, e);
    check_value({63'd0, e}, 64'd1, "err_o on unmapped read");
    host_write(32'h0000_0004, 32'hffff_ffff, e);
    check_value({63'd0, e}, 64'd1, "err_o on unmapped write");
    host_write(CTRLSTS_ADDR, 32'hffff_ffff, e);
    check_value({63'd0, e}, 64'd0, "err_o on control/status write");
    check_key_status(1'b0);

    finish_run();
  end

endmodule

`default_nettype wire
